/* verilog/cfg_bus_pkg.sv */
package cfg_bus_pkg;

	typedef logic [31:0] data_word_t;
	typedef logic [3:0]  strobe_t;
	typedef logic [14:0] bus_addr_t;	// Address width the targets decode

	// Request address word
	// Routing reads it as page and offset, the master reads it as bus address
	typedef union packed {
		struct packed {
			logic [19:0] page;
			logic [11:0] offset;
		} map;
		struct packed {
			logic [16:0] unused;
			bus_addr_t   bus_addr;
		} bus;
	} cfg_addr_u;

	localparam data_word_t ALL_ONES_WORD = 32'hffff_ffff;	// Unmapped read return

endpackage

/* verilog/cfg_map_pkg.sv */
package cfg_map_pkg;

	localparam int NUM_EXT_TARGETS = 5;

	typedef logic [19:0] page_t;
	typedef logic [NUM_EXT_TARGETS-1:0] target_mask_t;	// One-hot over external targets

	// Page map
	localparam page_t EXT_PAGE_BASE  = 20'h30000;	// Target n answers at base + n
	localparam page_t CC_PAGE        = 20'h30005;	// Internal project select
	localparam page_t UNMAPPED_FIRST = 20'h30006;
	localparam page_t UNMAPPED_LAST  = 20'h3ffff;

	localparam logic [11:0] PRJ_SEL_OFFSET = 12'h000;	// Word 0 of the internal page

endpackage

/* verilog/wb_requester.sv */
`timescale 1ns/1ps

module wb_requester
	import cfg_bus_pkg::*;
(
	input  logic       axi_clk,
	input  logic       axi_reset_n,
	input  cfg_addr_u  wbs_adr_i,
	input  data_word_t wbs_wdata_i,
	input  strobe_t    wbs_sel_i,
	input  logic       wbs_cyc_i,
	input  logic       wbs_stb_i,
	input  logic       wbs_we_i,
	output logic       ack_o,
	output data_word_t rdata_o,
	output logic       req_o,
	output logic       write_o,
	output cfg_addr_u  addr_o,
	output data_word_t wdata_o,
	output strobe_t    strb_o,
	input  logic       ack_i,
	input  data_word_t rdata_i
);

	logic start;
	logic finish;

	// Cycle right after our own ack is skipped, and the old handshake must be closed
	assign start  = wbs_cyc_i && wbs_stb_i && !req_o && !ack_o && !ack_i;
	assign finish = req_o && ack_i;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			req_o   <= 1'b0;
			ack_o   <= 1'b0;
			write_o <= 1'b0;
			addr_o  <= '0;
		end else begin
			ack_o <= finish;	// One-cycle Wishbone ack
			if (start) begin
				req_o   <= 1'b1;
				write_o <= wbs_we_i;
				addr_o  <= wbs_adr_i;
			end else if (finish) begin
				req_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge axi_clk) begin
		if (start) begin
			wdata_o <= wbs_wdata_i;
			strb_o  <= wbs_sel_i;
		end
		if (finish)
			rdata_o <= rdata_i;	// Valid alongside ack_o
	end

endmodule

/* verilog/axil_requester.sv */
`timescale 1ns/1ps

module axil_requester
	import cfg_bus_pkg::*;
(
	input  logic       axi_clk,
	input  logic       axi_reset_n,
	input  logic       s_awvalid_i,
	input  cfg_addr_u  s_awaddr_i,
	input  logic       s_wvalid_i,
	input  data_word_t s_wdata_i,
	input  strobe_t    s_wstrb_i,
	input  logic       s_arvalid_i,
	input  cfg_addr_u  s_araddr_i,
	input  logic       s_rready_i,
	output logic       s_awready_o,
	output logic       s_wready_o,
	output logic       s_arready_o,
	output data_word_t s_rdata_o,
	output logic       s_rvalid_o,
	output logic       req_o,
	output logic       write_o,
	output cfg_addr_u  addr_o,
	output data_word_t wdata_o,
	output strobe_t    strb_o,
	input  logic       ack_i,
	input  data_word_t rdata_i
);

	localparam logic [2:0] st_idle       = 3'd0;
	localparam logic [2:0] st_read_wait  = 3'd1;
	localparam logic [2:0] st_read_done  = 3'd2;
	localparam logic [2:0] st_write_data = 3'd3;
	localparam logic [2:0] st_write_done = 3'd4;

	logic [2:0] state;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state       <= st_idle;
			req_o       <= 1'b0;
			write_o     <= 1'b0;
			addr_o      <= '0;
			s_awready_o <= 1'b0;
			s_wready_o  <= 1'b0;
			s_arready_o <= 1'b0;
			s_rvalid_o  <= 1'b0;
		end else begin
			s_awready_o <= 1'b0;
			s_wready_o  <= 1'b0;
			s_arready_o <= 1'b0;
			case (state)
				st_idle: begin
					if (!ack_i) begin	// Wait for the previous ack to fall
						if (s_awvalid_i) begin
							s_awready_o <= 1'b1;
							addr_o      <= s_awaddr_i;
							state       <= st_write_data;
						end else if (s_arvalid_i) begin
							s_arready_o <= 1'b1;
							addr_o      <= s_araddr_i;
							write_o     <= 1'b0;
							req_o       <= 1'b1;
							state       <= st_read_wait;
						end
					end
				end
				st_read_wait: begin
					if (ack_i) begin
						req_o      <= 1'b0;
						s_rvalid_o <= 1'b1;
						state      <= st_read_done;
					end
				end
				st_read_done: begin
					if (s_rready_i) begin	// Data held under back-pressure
						s_rvalid_o <= 1'b0;
						state      <= st_idle;
					end
				end
				st_write_data: begin
					if (s_wvalid_i) begin
						write_o <= 1'b1;
						req_o   <= 1'b1;
						state   <= st_write_done;
					end
				end
				st_write_done: begin
					if (ack_i) begin
						req_o      <= 1'b0;
						s_wready_o <= 1'b1;	// Write data taken only once the bus is done
						state      <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (state == st_write_data && s_wvalid_i) begin
			wdata_o <= s_wdata_i;
			strb_o  <= s_wstrb_i;
		end
		if (state == st_read_wait && ack_i)
			s_rdata_o <= rdata_i;
	end

endmodule

/* verilog/cfg_arbiter.sv */
`timescale 1ns/1ps

module cfg_arbiter
	import cfg_bus_pkg::*;
(
	input  logic       axi_clk,
	input  logic       axi_reset_n,
	input  logic       req_a_i,
	input  logic       write_a_i,
	input  cfg_addr_u  addr_a_i,
	input  data_word_t wdata_a_i,
	input  strobe_t    strb_a_i,
	output logic       ack_a_o,
	output data_word_t rdata_a_o,
	input  logic       req_b_i,
	input  logic       write_b_i,
	input  cfg_addr_u  addr_b_i,
	input  data_word_t wdata_b_i,
	input  strobe_t    strb_b_i,
	output logic       ack_b_o,
	output data_word_t rdata_b_o,
	output logic       req_o,
	output logic       write_o,
	output cfg_addr_u  addr_o,
	output data_word_t wdata_o,
	output strobe_t    strb_o,
	input  logic       done_i,
	input  data_word_t rdata_i
);

	logic       grant_q;	// 0 selects a, 1 selects b
	data_word_t rdata_q;

	// Grant moves only when the owner is idle and the other side asks
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			grant_q <= 1'b0;
			ack_a_o <= 1'b0;
			ack_b_o <= 1'b0;
		end else begin
			if (!grant_q && !req_a_i && req_b_i)
				grant_q <= 1'b1;
			else if (grant_q && !req_b_i && req_a_i)
				grant_q <= 1'b0;

			if (done_i && !grant_q)
				ack_a_o <= 1'b1;
			else if (!req_a_i)
				ack_a_o <= 1'b0;	// Falls a cycle after req drops

			if (done_i && grant_q)
				ack_b_o <= 1'b1;
			else if (!req_b_i)
				ack_b_o <= 1'b0;
		end
	end

	always_ff @(posedge axi_clk) begin
		if (done_i)
			rdata_q <= rdata_i;
	end

	// A finished request still holding req must not start the master again
	assign req_o   = (grant_q ? (req_b_i && !ack_b_o) : (req_a_i && !ack_a_o)) && !done_i;
	assign write_o = grant_q ? write_b_i : write_a_i;
	assign addr_o  = grant_q ? addr_b_i  : addr_a_i;
	assign wdata_o = grant_q ? wdata_b_i : wdata_a_i;
	assign strb_o  = grant_q ? strb_b_i  : strb_a_i;

	assign rdata_a_o = rdata_q;
	assign rdata_b_o = rdata_q;

endmodule

/* verilog/axil_master.sv */
`timescale 1ns/1ps

module axil_master
	import cfg_bus_pkg::*;
(
	input  logic       axi_clk,
	input  logic       axi_reset_n,
	input  logic       req_i,
	input  logic       write_i,
	input  cfg_addr_u  addr_i,
	input  data_word_t wdata_i,
	input  strobe_t    strb_i,
	output logic       done_o,
	output data_word_t rdata_o,
	output logic       m_awvalid_o,
	output bus_addr_t  m_awaddr_o,
	output logic       m_wvalid_o,
	output data_word_t m_wdata_o,
	output strobe_t    m_wstrb_o,
	output logic       m_arvalid_o,
	output bus_addr_t  m_araddr_o,
	output logic       m_rready_o,
	input  logic       bus_awready_i,
	input  logic       bus_wready_i,
	input  logic       bus_arready_i,
	input  logic       bus_rvalid_i,
	input  data_word_t bus_rdata_i
);

	localparam logic [2:0] st_idle           = 3'd0;
	localparam logic [2:0] st_read_data      = 3'd1;
	localparam logic [2:0] st_read_complete  = 3'd2;
	localparam logic [2:0] st_write_data     = 3'd3;
	localparam logic [2:0] st_write_complete = 3'd4;

	logic [2:0] state;
	logic       start;
	logic       read_fire;
	logic       write_fire;

	assign start = (state == st_idle) && req_i;

	// Each channel counts as finished once its valid was released or is taken now
	assign read_fire  = bus_rvalid_i && (!m_arvalid_o || bus_arready_i);
	assign write_fire = (!m_awvalid_o || bus_awready_i) && (!m_wvalid_o || bus_wready_i);

	////////////////////////////////////////////////////////////////////////////
	// Bus state machine
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state       <= st_idle;
			done_o      <= 1'b0;
			m_awvalid_o <= 1'b0;
			m_wvalid_o  <= 1'b0;
			m_arvalid_o <= 1'b0;
			m_rready_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				st_idle: begin
					if (start && write_i) begin
						m_awvalid_o <= 1'b1;
						m_wvalid_o  <= 1'b1;
						state       <= st_write_data;
					end else if (start) begin
						m_arvalid_o <= 1'b1;
						m_rready_o  <= 1'b1;
						state       <= st_read_data;
					end
				end
				st_read_data, st_read_complete: begin
					if (read_fire) begin
						m_arvalid_o <= 1'b0;
						m_rready_o  <= 1'b0;
						done_o      <= 1'b1;
						state       <= st_idle;
					end else if (bus_arready_i) begin
						m_arvalid_o <= 1'b0;	// Address taken, data still to come
						state       <= st_read_complete;
					end
				end
				st_write_data, st_write_complete: begin
					if (write_fire) begin
						m_awvalid_o <= 1'b0;
						m_wvalid_o  <= 1'b0;
						done_o      <= 1'b1;
						state       <= st_idle;
					end else begin
						if (bus_awready_i)
							m_awvalid_o <= 1'b0;
						if (bus_wready_i)
							m_wvalid_o <= 1'b0;
						state <= st_write_complete;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge axi_clk) begin
		if (start) begin
			m_awaddr_o <= addr_i.bus.bus_addr;
			m_araddr_o <= addr_i.bus.bus_addr;
			m_wdata_o  <= wdata_i;
			m_wstrb_o  <= strb_i;
		end
		if (m_rready_o && read_fire)
			rdata_o <= bus_rdata_i;
	end

endmodule

/* verilog/target_router.sv */
`timescale 1ns/1ps

module target_router
	import cfg_bus_pkg::*, cfg_map_pkg::*;
#(
	parameter int PRJ_SEL_WIDTH = 5
) (
	input  logic                     axi_clk,
	input  logic                     axi_reset_n,
	input  cfg_addr_u                addr_i,
	input  logic                     m_awvalid_i,
	input  bus_addr_t                m_awaddr_i,
	input  logic                     m_wvalid_i,
	input  data_word_t               m_wdata_i,
	input  strobe_t                  m_wstrb_i,
	input  logic                     m_arvalid_i,
	input  target_mask_t             tgt_awready_i,
	input  target_mask_t             tgt_wready_i,
	input  target_mask_t             tgt_arready_i,
	input  target_mask_t             tgt_rvalid_i,
	input  data_word_t               tgt_rdata_i [NUM_EXT_TARGETS],
	output target_mask_t             tgt_enable_o,
	output logic                     bus_awready_o,
	output logic                     bus_wready_o,
	output logic                     bus_arready_o,
	output logic                     bus_rvalid_o,
	output data_word_t               bus_rdata_o,
	output logic [PRJ_SEL_WIDTH-1:0] user_prj_sel_o
);

	page_t page;
	logic  cc_en;
	logic  unmapped_en;
	logic  prj_sel_wr;

	assign page = addr_i.map.page;

	// Decode lags the granted address by one cycle
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			tgt_enable_o <= '0;
			cc_en        <= 1'b0;
			unmapped_en  <= 1'b0;
		end else begin
			for (int n = 0; n < NUM_EXT_TARGETS; n++)
				tgt_enable_o[n] <= (page == EXT_PAGE_BASE + page_t'(n));
			cc_en       <= (page == CC_PAGE);
			unmapped_en <= (page >= UNMAPPED_FIRST) && (page <= UNMAPPED_LAST);
		end
	end

	// Internal register answers at once, unmapped pages echo the valids
	always_comb begin
		bus_awready_o = |(tgt_awready_i & tgt_enable_o) | ((cc_en | unmapped_en) & m_awvalid_i);
		bus_wready_o  = |(tgt_wready_i & tgt_enable_o) | ((cc_en | unmapped_en) & m_wvalid_i);
		bus_arready_o = |(tgt_arready_i & tgt_enable_o) | cc_en | (unmapped_en & m_arvalid_i);
		bus_rvalid_o  = |(tgt_rvalid_i & tgt_enable_o) | cc_en | (unmapped_en & m_arvalid_i);
		bus_rdata_o   = cc_en ? data_word_t'(user_prj_sel_o) : '0;
		if (unmapped_en)
			bus_rdata_o = bus_rdata_o | ALL_ONES_WORD;
		for (int n = 0; n < NUM_EXT_TARGETS; n++) begin
			if (tgt_enable_o[n])
				bus_rdata_o = bus_rdata_o | tgt_rdata_i[n];
		end
	end

	assign prj_sel_wr = cc_en && m_awvalid_i && m_wvalid_i && m_wstrb_i[0]
		&& (m_awaddr_i[11:0] == PRJ_SEL_OFFSET);

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n)
			user_prj_sel_o <= '0;
		else if (prj_sel_wr)
			user_prj_sel_o <= m_wdata_i[PRJ_SEL_WIDTH-1:0];	// Byte 0 only
	end

endmodule

/* verilog/cfg_ctrl.sv */
`timescale 1ns/1ps

module cfg_ctrl
	import cfg_bus_pkg::*, cfg_map_pkg::*;
#(
	parameter int PRJ_SEL_WIDTH = 5
) (
	input  logic                     axi_clk,
	input  logic                     axi_reset_n,
	// Wishbone slave
	input  cfg_addr_u                wbs_adr_i,
	input  data_word_t               wbs_wdata_i,
	input  strobe_t                  wbs_sel_i,
	input  logic                     wbs_cyc_i,
	input  logic                     wbs_stb_i,
	input  logic                     wbs_we_i,
	output logic                     wbs_ack_o,
	output data_word_t               wbs_rdata_o,
	// AXI-Lite slave
	input  logic                     s_awvalid_i,
	input  cfg_addr_u                s_awaddr_i,
	input  logic                     s_wvalid_i,
	input  data_word_t               s_wdata_i,
	input  strobe_t                  s_wstrb_i,
	input  logic                     s_arvalid_i,
	input  cfg_addr_u                s_araddr_i,
	input  logic                     s_rready_i,
	output logic                     s_awready_o,
	output logic                     s_wready_o,
	output logic                     s_arready_o,
	output data_word_t               s_rdata_o,
	output logic                     s_rvalid_o,
	// AXI-Lite master toward the targets
	output logic                     m_awvalid_o,
	output bus_addr_t                m_awaddr_o,
	output logic                     m_wvalid_o,
	output data_word_t               m_wdata_o,
	output strobe_t                  m_wstrb_o,
	output logic                     m_arvalid_o,
	output bus_addr_t                m_araddr_o,
	output logic                     m_rready_o,
	input  target_mask_t             tgt_awready_i,
	input  target_mask_t             tgt_wready_i,
	input  target_mask_t             tgt_arready_i,
	input  target_mask_t             tgt_rvalid_i,
	input  data_word_t               tgt_rdata_i [NUM_EXT_TARGETS],
	output target_mask_t             tgt_enable_o,
	output logic [PRJ_SEL_WIDTH-1:0] user_prj_sel_o
);

	// Wishbone side request
	logic       wb_req, wb_write, wb_ack;
	cfg_addr_u  wb_addr;
	data_word_t wb_wdata, wb_rdata;
	strobe_t    wb_strb;

	// AXI-Lite slave side request
	logic       ax_req, ax_write, ax_ack;
	cfg_addr_u  ax_addr;
	data_word_t ax_wdata, ax_rdata;
	strobe_t    ax_strb;

	// Granted request and master return
	logic       mst_req, mst_write, mst_done;
	cfg_addr_u  mst_addr;
	data_word_t mst_wdata, mst_rdata;
	strobe_t    mst_strb;

	logic       bus_awready, bus_wready, bus_arready, bus_rvalid;
	data_word_t bus_rdata;

	////////////////////////////////////////////////////////////////////////////
	// Requesters and arbiter
	////////////////////////////////////////////////////////////////////////////
	wb_requester u_wb_req (
		.axi_clk, .axi_reset_n,
		.wbs_adr_i, .wbs_wdata_i, .wbs_sel_i, .wbs_cyc_i, .wbs_stb_i, .wbs_we_i,
		.ack_o   (wbs_ack_o),
		.rdata_o (wbs_rdata_o),
		.req_o   (wb_req),
		.write_o (wb_write),
		.addr_o  (wb_addr),
		.wdata_o (wb_wdata),
		.strb_o  (wb_strb),
		.ack_i   (wb_ack),
		.rdata_i (wb_rdata)
	);

	axil_requester u_axil_req (
		.axi_clk, .axi_reset_n,
		.s_awvalid_i, .s_awaddr_i, .s_wvalid_i, .s_wdata_i, .s_wstrb_i,
		.s_arvalid_i, .s_araddr_i, .s_rready_i,
		.s_awready_o, .s_wready_o, .s_arready_o, .s_rdata_o, .s_rvalid_o,
		.req_o   (ax_req),
		.write_o (ax_write),
		.addr_o  (ax_addr),
		.wdata_o (ax_wdata),
		.strb_o  (ax_strb),
		.ack_i   (ax_ack),
		.rdata_i (ax_rdata)
	);

	cfg_arbiter u_arb (
		.axi_clk, .axi_reset_n,
		.req_a_i (wb_req), .write_a_i (wb_write), .addr_a_i (wb_addr),
		.wdata_a_i (wb_wdata), .strb_a_i (wb_strb),
		.ack_a_o (wb_ack), .rdata_a_o (wb_rdata),
		.req_b_i (ax_req), .write_b_i (ax_write), .addr_b_i (ax_addr),
		.wdata_b_i (ax_wdata), .strb_b_i (ax_strb),
		.ack_b_o (ax_ack), .rdata_b_o (ax_rdata),
		.req_o   (mst_req),
		.write_o (mst_write),
		.addr_o  (mst_addr),
		.wdata_o (mst_wdata),
		.strb_o  (mst_strb),
		.done_i  (mst_done),
		.rdata_i (mst_rdata)
	);

	////////////////////////////////////////////////////////////////////////////
	// Bus master and target routing
	////////////////////////////////////////////////////////////////////////////
	axil_master u_master (
		.axi_clk, .axi_reset_n,
		.req_i   (mst_req),
		.write_i (mst_write),
		.addr_i  (mst_addr),
		.wdata_i (mst_wdata),
		.strb_i  (mst_strb),
		.done_o  (mst_done),
		.rdata_o (mst_rdata),
		.m_awvalid_o, .m_awaddr_o, .m_wvalid_o, .m_wdata_o, .m_wstrb_o,
		.m_arvalid_o, .m_araddr_o, .m_rready_o,
		.bus_awready_i (bus_awready),
		.bus_wready_i  (bus_wready),
		.bus_arready_i (bus_arready),
		.bus_rvalid_i  (bus_rvalid),
		.bus_rdata_i   (bus_rdata)
	);

	target_router #(
		.PRJ_SEL_WIDTH (PRJ_SEL_WIDTH)
	) u_router (
		.axi_clk, .axi_reset_n,
		.addr_i      (mst_addr),	// Decoded ahead of the master's valids
		.m_awvalid_i (m_awvalid_o),
		.m_awaddr_i  (m_awaddr_o),
		.m_wvalid_i  (m_wvalid_o),
		.m_wdata_i   (m_wdata_o),
		.m_wstrb_i   (m_wstrb_o),
		.m_arvalid_i (m_arvalid_o),
		.tgt_awready_i, .tgt_wready_i, .tgt_arready_i, .tgt_rvalid_i, .tgt_rdata_i,
		.tgt_enable_o,
		.bus_awready_o (bus_awready),
		.bus_wready_o  (bus_wready),
		.bus_arready_o (bus_arready),
		.bus_rvalid_o  (bus_rvalid),
		.bus_rdata_o   (bus_rdata),
		.user_prj_sel_o
	);

endmodule

/* verification/cfg_ctrl_tb.sv */
`timescale 1ns/1ps

module cfg_ctrl_tb
	import cfg_bus_pkg::*, cfg_map_pkg::*;
;

	localparam int PRJ_SEL_WIDTH = 5;
	localparam int NUM_TXN       = 49;	// Transactions issued over the whole run

	logic axi_clk = 1'b0;
	logic axi_reset_n;
	cfg_addr_u wbs_adr_i, s_awaddr_i, s_araddr_i;
	data_word_t wbs_wdata_i, wbs_rdata_o, s_wdata_i, s_rdata_o, m_wdata_o;
	strobe_t wbs_sel_i, s_wstrb_i, m_wstrb_o;
	logic wbs_cyc_i, wbs_stb_i, wbs_we_i, wbs_ack_o;
	logic s_awvalid_i, s_wvalid_i, s_arvalid_i, s_rready_i;
	logic s_awready_o, s_wready_o, s_arready_o, s_rvalid_o;
	logic m_awvalid_o, m_wvalid_o, m_arvalid_o, m_rready_o;
	bus_addr_t m_awaddr_o, m_araddr_o;
	target_mask_t tgt_awready_i, tgt_wready_i, tgt_arready_i, tgt_rvalid_i, tgt_enable_o;
	data_word_t tgt_rdata_i [NUM_EXT_TARGETS];
	logic [PRJ_SEL_WIDTH-1:0] user_prj_sel_o;

	logic [31:0] model_seed = 32'hefa9_bced;
	logic [31:0] stim_seed;
	logic [1:0]  wait_cnt;
	logic        responded;
	int          wr_tgt[$];
	bus_addr_t   wr_addr[$];
	data_word_t  wr_data[$];
	strobe_t     wr_strb[$];

	cfg_ctrl #(.PRJ_SEL_WIDTH(PRJ_SEL_WIDTH)) UUT (.*);

	always #2 axi_clk = ~axi_clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected target read data, a fixed mix of index and bus address
	function automatic data_word_t tgt_read_value(input int idx, input bus_addr_t addr);
		return {4'ha, 4'(idx), 9'h0, addr} ^ {addr[7:0], 24'h0};
	endfunction

	task automatic check_word(input data_word_t got, input data_word_t exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, msg, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_mask(input target_mask_t got, input target_mask_t exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, msg, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_sel(input logic [PRJ_SEL_WIDTH-1:0] got,
			input logic [PRJ_SEL_WIDTH-1:0] exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, msg, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Target models
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int n = 0; n < NUM_EXT_TARGETS; n++)
			tgt_rdata_i[n] = tgt_read_value(n, m_araddr_o);
	end

	always @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			{tgt_awready_i, tgt_wready_i, tgt_arready_i, tgt_rvalid_i} <= '0;
			wait_cnt  <= '0;
			responded <= 1'b0;
		end else begin
			{tgt_awready_i, tgt_wready_i, tgt_arready_i, tgt_rvalid_i} <= '0;
			if (responded) begin	// Master drops its valids on this edge
				responded  <= 1'b0;
				model_seed <= lcg_next(model_seed);
				wait_cnt   <= model_seed[17:16];
			end else if ((m_arvalid_o && m_rready_o) || (m_awvalid_o && m_wvalid_o)) begin
				if (wait_cnt != 0) begin
					wait_cnt <= wait_cnt - 1'b1;
				end else if (m_arvalid_o) begin
					tgt_arready_i <= tgt_enable_o;
					tgt_rvalid_i  <= tgt_enable_o;
					responded     <= 1'b1;
				end else begin
					tgt_awready_i <= tgt_enable_o;
					tgt_wready_i  <= tgt_enable_o;
					responded     <= 1'b1;
					for (int n = 0; n < NUM_EXT_TARGETS; n++) begin
						if (tgt_enable_o[n]) begin
							wr_tgt.push_back(n);
							wr_addr.push_back(m_awaddr_o);
							wr_data.push_back(m_wdata_o);
							wr_strb.push_back(m_wstrb_o);
						end
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Requester tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic wb_access(input logic wr, input logic [31:0] addr, input data_word_t data,
			input strobe_t sel, output data_word_t rdata, output target_mask_t mask);
		@(posedge axi_clk);
		wbs_cyc_i   <= 1'b1;
		wbs_stb_i   <= 1'b1;
		wbs_we_i    <= wr;
		wbs_adr_i   <= cfg_addr_u'(addr);
		wbs_wdata_i <= data;
		wbs_sel_i   <= sel;
		mask = '0;
		@(posedge axi_clk);
		while (!wbs_ack_o) begin
			if (m_arvalid_o || m_awvalid_o)
				mask |= tgt_enable_o;
			@(posedge axi_clk);
		end
		rdata = wbs_rdata_o;
		wbs_cyc_i <= 1'b0;
		wbs_stb_i <= 1'b0;
		wbs_we_i  <= 1'b0;
	endtask

	task automatic axil_write(input logic [31:0] addr, input data_word_t data,
			input strobe_t strb, output target_mask_t mask);
		@(posedge axi_clk);
		s_awvalid_i <= 1'b1;
		s_awaddr_i  <= cfg_addr_u'(addr);
		s_wvalid_i  <= 1'b1;
		s_wdata_i   <= data;
		s_wstrb_i   <= strb;
		mask = '0;
		@(posedge axi_clk);
		while (!s_awready_o)
			@(posedge axi_clk);
		s_awvalid_i <= 1'b0;
		while (!s_wready_o) begin
			if (m_awvalid_o)
				mask |= tgt_enable_o;
			@(posedge axi_clk);
		end
		s_wvalid_i <= 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output data_word_t rdata);
		@(posedge axi_clk);
		s_arvalid_i <= 1'b1;
		s_araddr_i  <= cfg_addr_u'(addr);
		@(posedge axi_clk);
		while (!s_arready_o)
			@(posedge axi_clk);
		s_arvalid_i <= 1'b0;
		forever begin
			@(posedge axi_clk);
			if (s_rvalid_o && s_rready_i)
				break;
			stim_seed = lcg_next(stim_seed);
			s_rready_i <= stim_seed[20];	// Random back-pressure
		end
		rdata = s_rdata_o;
		s_rready_i <= 1'b0;
	endtask

	function automatic logic [31:0] ext_addr(input int n, input logic [11:0] offset);
		return {EXT_PAGE_BASE + page_t'(n), offset};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin
		data_word_t   rd;
		target_mask_t mask;
		logic [31:0]  addr;
		axi_reset_n = 1'b0;
		stim_seed   = lcg_next(32'hefa9_bced);
		{wbs_cyc_i, wbs_stb_i, wbs_we_i, s_awvalid_i, s_wvalid_i, s_arvalid_i, s_rready_i} = '0;
		wbs_adr_i = '0;
		s_awaddr_i = '0;
		s_araddr_i = '0;
		{wbs_wdata_i, s_wdata_i, wbs_sel_i, s_wstrb_i} = '0;
		repeat (2) @(posedge axi_clk);
		axi_reset_n <= 1'b1;

		// Wishbone reads from every external target
		for (int n = 0; n < NUM_EXT_TARGETS; n++) begin
			addr = ext_addr(n, 12'(12'h10 * n + 12'h4));
			wb_access(1'b0, addr, '0, 4'hf, rd, mask);
			check_word(rd, tgt_read_value(n, addr[14:0]), "wishbone target read");
			check_mask(mask, target_mask_t'(1 << n), "enable during read");
		end

		// AXI-Lite writes land on the addressed target
		for (int n = 0; n < NUM_EXT_TARGETS; n++) begin
			addr = ext_addr(n, 12'h100 + 12'(n));
			axil_write(addr, 32'hc0de_0000 + n, strobe_t'(n + 1), mask);
			check_mask(mask, target_mask_t'(1 << n), "enable during write");
			check_word(data_word_t'(wr_tgt.size()), 32'd1, "one write recorded");
			check_word(data_word_t'(wr_tgt.pop_front()), data_word_t'(n), "write target");
			check_word(data_word_t'(wr_addr.pop_front()), data_word_t'(addr[14:0]), "write addr");
			check_word(wr_data.pop_front(), 32'hc0de_0000 + n, "write data");
			check_word(data_word_t'(wr_strb.pop_front()), data_word_t'(n + 1), "write strobe");
		end

		// Project select register
		axil_write({CC_PAGE, PRJ_SEL_OFFSET}, 32'hffff_ff13, 4'b0001, mask);
		check_sel(user_prj_sel_o, 5'h13, "select after write");
		axil_write({CC_PAGE, PRJ_SEL_OFFSET}, 32'h0000_000a, 4'b1110, mask);
		check_sel(user_prj_sel_o, 5'h13, "select with byte 0 masked");
		wb_access(1'b0, {CC_PAGE, PRJ_SEL_OFFSET}, '0, 4'hf, rd, mask);
		check_word(rd, 32'h0000_0013, "select readback");

		// Unmapped pages
		axil_write({UNMAPPED_FIRST, 12'h004}, 32'h1234_5678, 4'hf, mask);
		check_mask(mask, '0, "no enable on unmapped write");
		wb_access(1'b1, {UNMAPPED_LAST, 12'hffc}, 32'h8765_4321, 4'hf, rd, mask);
		check_mask(mask, '0, "no enable on unmapped write");
		wb_access(1'b0, {UNMAPPED_FIRST, 12'h008}, '0, 4'hf, rd, mask);
		check_word(rd, ALL_ONES_WORD, "unmapped wishbone read");
		check_mask(mask, '0, "no enable on unmapped read");
		axil_read({UNMAPPED_LAST, 12'h010}, rd);
		check_word(rd, ALL_ONES_WORD, "unmapped axi read");
		check_word(data_word_t'(wr_tgt.size()), 32'd0, "no target write recorded");

		// Both requesters at once
		fork
			for (int i = 0; i < 16; i++) begin
				data_word_t   wb_rd;
				target_mask_t wb_mask;
				logic [31:0]  wb_addr;
				int           t;
				stim_seed = lcg_next(stim_seed);
				t = int'(stim_seed[31:24] % NUM_EXT_TARGETS);
				wb_addr = ext_addr(t, stim_seed[11:0]);
				wb_access(1'b0, wb_addr, '0, 4'hf, wb_rd, wb_mask);
				check_word(wb_rd, tgt_read_value(t, wb_addr[14:0]), "overlapped wishbone read");
			end
			for (int i = 0; i < 16; i++) begin
				data_word_t  ax_rd;
				logic [31:0] ax_addr;
				int          t;
				stim_seed = lcg_next(stim_seed);
				t = int'(stim_seed[23:16] % NUM_EXT_TARGETS);
				ax_addr = ext_addr(t, stim_seed[27:16]);
				axil_read(ax_addr, ax_rd);
				check_word(ax_rd, tgt_read_value(t, ax_addr[14:0]), "overlapped axi read");
			end
		join

		$display("all tests passed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (200 * NUM_TXN) @(posedge axi_clk);
		$display("Timeout: the run hung before all transactions completed");
		$display("tests failed");
		$fatal(1);
	end

endmodule

/* cfg_ctrl.f */
verilog/cfg_bus_pkg.sv
verilog/cfg_map_pkg.sv
verilog/wb_requester.sv
verilog/axil_requester.sv
verilog/cfg_arbiter.sv
verilog/axil_master.sv
verilog/target_router.sv
verilog/cfg_ctrl.sv
verification/cfg_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the cfg_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cfg_ctrl_tb \
	-f cfg_ctrl.f --Mdir obj_dir -o cfg_ctrl_sim
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/cfg_ctrl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit 1
fi

if grep -q "all tests passed" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
